// File: rtl/decodePkg.sv
/*
 * Shared encodings for the RV32I decode stage.
 * Opcodes, funct3/funct7 values, ALU, memory, immediate and select codes,
 * plus the instruction word type. Modules pull these in by wildcard import.
 */

package decodePkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int xlen         = 32;                // Data width
    localparam int regAddrWidth = 5;                 // Register address width

    // Major opcodes
    localparam logic [6:0] opR      = 7'b0110011;    // Register ALU ops
    localparam logic [6:0] opI      = 7'b0010011;    // Immediate ALU ops
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opFence  = 7'b0001111;    // FENCE and PAUSE
    localparam logic [6:0] opSystem = 7'b1110011;    // ECALL and EBREAK

    // funct3 for ALU ops, R and I forms alike
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Jalr   = 3'b000;        // Only legal JALR value

    // funct3 for loads and stores
    localparam logic [2:0] f3Lb  = 3'b000;
    localparam logic [2:0] f3Lh  = 3'b001;
    localparam logic [2:0] f3Lw  = 3'b010;
    localparam logic [2:0] f3Lbu = 3'b100;
    localparam logic [2:0] f3Lhu = 3'b101;
    localparam logic [2:0] f3Sb  = 3'b000;
    localparam logic [2:0] f3Sh  = 3'b001;
    localparam logic [2:0] f3Sw  = 3'b010;

    // funct3 for branch conditions
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // funct7
    localparam logic [6:0] f7Alt = 7'b0100000;       // SUB, SRA, SRAI
    localparam logic [6:0] f7Mul = 7'b0000001;       // M extension, not supported

    //////////////////////////////////////////////////
    // Control codes
    //////////////////////////////////////////////////
    localparam logic [3:0] aluAdd  = 4'd0;
    localparam logic [3:0] aluSub  = 4'd1;
    localparam logic [3:0] aluSll  = 4'd2;
    localparam logic [3:0] aluSlt  = 4'd3;           // Also BLT
    localparam logic [3:0] aluSltu = 4'd4;           // Also BLTU
    localparam logic [3:0] aluXor  = 4'd5;
    localparam logic [3:0] aluSrl  = 4'd6;
    localparam logic [3:0] aluSra  = 4'd7;
    localparam logic [3:0] aluOr   = 4'd8;
    localparam logic [3:0] aluAnd  = 4'd9;
    localparam logic [3:0] aluLui  = 4'd10;          // Pass operand B
    localparam logic [3:0] aluBeq  = 4'd11;
    localparam logic [3:0] aluBne  = 4'd12;
    localparam logic [3:0] aluBge  = 4'd13;
    localparam logic [3:0] aluBgeu = 4'd14;

    localparam logic [2:0] memByte         = 3'd0;
    localparam logic [2:0] memByteUnsigned = 3'd1;
    localparam logic [2:0] memHalf         = 3'd2;
    localparam logic [2:0] memHalfUnsigned = 3'd3;
    localparam logic [2:0] memWord         = 3'd4;

    localparam logic [2:0] immI = 3'd0;
    localparam logic [2:0] immS = 3'd1;
    localparam logic [2:0] immB = 3'd2;
    localparam logic [2:0] immU = 3'd3;
    localparam logic [2:0] immJ = 3'd4;

    localparam logic [1:0] resultAlu = 2'd0;
    localparam logic [1:0] resultMem = 2'd1;
    localparam logic [1:0] resultPc4 = 2'd2;         // 2'd3 unused

    localparam logic srcAReg   = 1'b0;
    localparam logic srcAPc    = 1'b1;
    localparam logic srcBReg   = 1'b0;
    localparam logic srcBImm   = 1'b1;
    localparam logic branchPc  = 1'b0;
    localparam logic branchReg = 1'b1;               // JALR target base

    // Same 32 bits seen raw or split into R-format fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [6:0]              funct7;
            logic [regAddrWidth-1:0] rs2;
            logic [regAddrWidth-1:0] rs1;
            logic [2:0]              funct3;
            logic [regAddrWidth-1:0] rd;
            logic [6:0]              opcode;
        } r;
    } instrWord;

endpackage

// File: rtl/controlUnit.sv
/*
 * Main decoder of the decode stage. Purely combinational.
 * Turns opcode, funct3 and funct7 into enables and select codes.
 * Anything unsupported leaves every enable low, so it acts as a no-op.
 */

`timescale 1ns/1ps

module controlUnit import decodePkg::*; (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    output logic       regWrite,
    output logic       memWrite,
    output logic       jump,
    output logic       branch,
    output logic [2:0] memCtl,     // Access size and extension
    output logic [3:0] aluCtl,
    output logic [2:0] immSel,     // To immediate extender
    output logic       branchSrc,  // PC or rs1 as target base
    output logic       srcASel,
    output logic       srcBSel,
    output logic [1:0] resultSel
);

    always_comb begin
        // Safe defaults, nothing changes state
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        jump      = 1'b0;
        branch    = 1'b0;
        memCtl    = memByte;
        aluCtl    = aluAdd;
        immSel    = immI;
        branchSrc = branchPc;
        srcASel   = srcAReg;
        srcBSel   = srcBReg;
        resultSel = resultAlu;

        case (opcode)
            //////////////////////////////////////////////////
            // ALU instructions
            //////////////////////////////////////////////////
            opR: begin
                if (funct7 != f7Mul) begin                          // MUL stays a no-op
                    regWrite = 1'b1;
                    case (funct3)
                        f3AddSub: aluCtl = (funct7 == f7Alt) ? aluSub : aluAdd;
                        f3Sll:    aluCtl = aluSll;
                        f3Slt:    aluCtl = aluSlt;
                        f3Sltu:   aluCtl = aluSltu;
                        f3Xor:    aluCtl = aluXor;
                        f3SrlSra: aluCtl = (funct7 == f7Alt) ? aluSra : aluSrl;
                        f3Or:     aluCtl = aluOr;
                        f3And:    aluCtl = aluAnd;
                        default:  ;
                    endcase
                end
            end
            opI: begin
                regWrite = 1'b1;
                srcBSel  = srcBImm;                                 // Immediate operand
                case (funct3)
                    f3AddSub: aluCtl = aluAdd;                      // ADDI, no SUBI
                    f3Sll:    aluCtl = aluSll;
                    f3Slt:    aluCtl = aluSlt;
                    f3Sltu:   aluCtl = aluSltu;
                    f3Xor:    aluCtl = aluXor;
                    f3SrlSra: aluCtl = (funct7 == f7Alt) ? aluSra : aluSrl; // Shamt upper bits
                    f3Or:     aluCtl = aluOr;
                    f3And:    aluCtl = aluAnd;
                    default:  ;
                endcase
            end

            //////////////////////////////////////////////////
            // Jumps and branches
            //////////////////////////////////////////////////
            opJalr: begin
                if (funct3 == f3Jalr) begin
                    regWrite  = 1'b1;                               // Link register
                    jump      = 1'b1;
                    branchSrc = branchReg;                          // rs1 + imm target
                    srcBSel   = srcBImm;
                    resultSel = resultPc4;
                end
            end
            opJal: begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                immSel    = immJ;
                resultSel = resultPc4;                              // Return address
            end
            opBranch: begin
                immSel = immB;
                branch = 1'b1;                                      // Cleared below if illegal
                case (funct3)
                    f3Beq:   aluCtl = aluBeq;
                    f3Bne:   aluCtl = aluBne;
                    f3Blt:   aluCtl = aluSlt;
                    f3Bge:   aluCtl = aluBge;
                    f3Bltu:  aluCtl = aluSltu;
                    f3Bgeu:  aluCtl = aluBgeu;
                    default: branch = 1'b0;                         // 010 and 011
                endcase
            end

            // Memory access, address is rs1 + imm
            opLoad: begin
                srcBSel   = srcBImm;
                resultSel = resultMem;
                regWrite  = 1'b1;
                case (funct3)
                    f3Lb:    memCtl = memByte;
                    f3Lbu:   memCtl = memByteUnsigned;
                    f3Lh:    memCtl = memHalf;
                    f3Lhu:   memCtl = memHalfUnsigned;
                    f3Lw:    memCtl = memWord;
                    default: regWrite = 1'b0;                       // LWU, LD
                endcase
            end
            opStore: begin
                srcBSel  = srcBImm;
                immSel   = immS;
                memWrite = 1'b1;
                case (funct3)
                    f3Sb:    memCtl = memByte;
                    f3Sh:    memCtl = memHalf;
                    f3Sw:    memCtl = memWord;
                    default: memWrite = 1'b0;                       // SD
                endcase
            end

            // Upper immediates
            opLui: begin
                regWrite = 1'b1;
                aluCtl   = aluLui;                                  // Pass imm through
                srcBSel  = srcBImm;
                immSel   = immU;
            end
            opAuipc: begin
                regWrite = 1'b1;
                srcASel  = srcAPc;                                  // PC + imm
                srcBSel  = srcBImm;
                immSel   = immU;
            end

            opFence, opSystem: ;                                    // Treated as no-ops
            default: ;                                              // Illegal opcode
        endcase
    end

endmodule

// File: rtl/registerFile.sv
/*
 * Integer register file with two combinational read ports and one write port.
 * Writes land on the rising edge. A same-cycle write is forwarded to reads.
 * x0 and addresses at or above numRegs read as zero and ignore writes.
 */

`timescale 1ns/1ps

module registerFile import decodePkg::*; #(
    parameter int numRegs = 32                  // 16 for an RV32E build
) (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    writeEn,
    input  logic [regAddrWidth-1:0] writeAddr,
    input  logic [xlen-1:0]         writeData,
    input  logic [regAddrWidth-1:0] readAddr1,
    input  logic [regAddrWidth-1:0] readAddr2,
    output logic [xlen-1:0]         readData1,
    output logic [xlen-1:0]         readData2
);

    logic [xlen-1:0] regs [numRegs];

    // Real register, not x0 and inside the array
    function automatic logic validAddr(input logic [regAddrWidth-1:0] addr);
        return (addr != '0) && (int'(addr) < numRegs);
    endfunction

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;                  // Defined reads after reset
            end
        end else if (writeEn && validAddr(writeAddr)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Read ports, forwarding takes priority over the stored value
    always_comb begin
        readData1 = '0;
        readData2 = '0;
        if (validAddr(readAddr1)) begin
            readData1 = (writeEn && readAddr1 == writeAddr) ? writeData : regs[readAddr1];
        end
        if (validAddr(readAddr2)) begin
            readData2 = (writeEn && readAddr2 == writeAddr) ? writeData : regs[readAddr2];
        end
    end

endmodule

// File: rtl/immediateExtender.sv
/*
 * Builds the 32-bit immediate for the format chosen by the control unit.
 * I, S, B and J are sign extended, U fills the low 12 bits with zeros.
 */

`timescale 1ns/1ps

module immediateExtender import decodePkg::*; (
    input  instrWord        instr,
    input  logic [2:0]      immSel,
    output logic [xlen-1:0] immExt
);

    logic [31:0] w;
    logic        sign;

    assign w    = instr.raw;                   // Immediate bits sit across field borders
    assign sign = instr.raw[31];               // Always the immediate MSB

    always_comb begin
        case (immSel)
            immI:    immExt = {{21{sign}}, w[30:20]};
            immS:    immExt = {{21{sign}}, w[30:25], w[11:7]};            // Split around rd slot
            immB:    immExt = {{20{sign}}, w[7], w[30:25], w[11:8], 1'b0}; // Halfword offset
            immU:    immExt = {w[31:12], 12'b0};
            immJ:    immExt = {{12{sign}}, w[19:12], w[20], w[30:21], 1'b0};
            default: immExt = '0;              // Unused select codes
        endcase
    end

endmodule

// File: rtl/decodeStage.sv
/*
 * Decode stage top level of the five-stage RV32I pipeline.
 * Splits the fetched instruction into fields and feeds the control unit,
 * register file and immediate extender. Writeback drives the write port.
 * All outputs are combinational from the instruction and register state.
 */

`timescale 1ns/1ps

module decodeStage import decodePkg::*; #(
    parameter int numRegs = 32
) (
    input  logic                    CLK,
    input  logic                    RST,
    input  instrWord                instr,       // From fetch
    input  logic                    regWriteEn,  // Writeback port
    input  logic [regAddrWidth-1:0] writeAddr,
    input  logic [xlen-1:0]         writeData,
    output logic                    regWrite,
    output logic                    memWrite,
    output logic                    jump,
    output logic                    branch,
    output logic [2:0]              memCtl,
    output logic [3:0]              aluCtl,
    output logic                    branchSrc,
    output logic                    srcASel,
    output logic                    srcBSel,
    output logic [1:0]              resultSel,
    output logic [regAddrWidth-1:0] rd,          // Hazard unit
    output logic [regAddrWidth-1:0] rs1,
    output logic [regAddrWidth-1:0] rs2,
    output logic [xlen-1:0]         readData1,
    output logic [xlen-1:0]         readData2,
    output logic [xlen-1:0]         immExt
);

    logic [2:0] immSel;                          // Control unit to extender

    // Register fields straight from the union view
    assign rd  = instr.r.rd;
    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;

    controlUnit ctrl (
        .opcode    (instr.r.opcode),
        .funct3    (instr.r.funct3),
        .funct7    (instr.r.funct7),
        .regWrite  (regWrite),
        .memWrite  (memWrite),
        .jump      (jump),
        .branch    (branch),
        .memCtl    (memCtl),
        .aluCtl    (aluCtl),
        .immSel    (immSel),
        .branchSrc (branchSrc),
        .srcASel   (srcASel),
        .srcBSel   (srcBSel),
        .resultSel (resultSel)
    );

    registerFile #(
        .numRegs (numRegs)
    ) regFile (
        .CLK       (CLK),
        .RST       (RST),
        .writeEn   (regWriteEn),
        .writeAddr (writeAddr),
        .writeData (writeData),
        .readAddr1 (instr.r.rs1),
        .readAddr2 (instr.r.rs2),
        .readData1 (readData1),
        .readData2 (readData2)
    );

    immediateExtender immExtender (
        .instr  (instr),                         // Whole word, raw view inside
        .immSel (immSel),
        .immExt (immExt)
    );

endmodule

// File: tests/tbClock.sv
/*
 * Clock and reset source for the decode stage testbench.
 * Free-running clock, reset held high for a fixed number of cycles.
 */

`timescale 1ns/1ps

module tbClock #(
    parameter int periodNs    = 20,
    parameter int resetCycles = 10
) (
    output logic CLK,
    output logic RST
);

    initial begin
        CLK = 1'b0;
        forever #(periodNs / 2) CLK = ~CLK;        // Rising edges at 10, 30, 50 ns
    end

    initial begin
        RST = 1'b1;
        repeat (resetCycles) @(posedge CLK);
        #1 RST = 1'b0;                              // Released just after the last reset edge
    end

endmodule

// File: tests/decodeStageTb.sv
/*
 * Testbench for the decode stage.
 * Loads cases from tests/decodeCases.txt, drives one case per clock cycle
 * and compares every output with the expected columns of that case.
 * Register writes land on the edge after the case that carries them.
 */

`timescale 1ns/1ps

module decodeStageTb import decodePkg::*; ();

    localparam int periodNs    = 20;
    localparam int resetCycles = 10;
    localparam int maxCases    = 64;
    localparam int numFields   = 17;                // Columns after the case name

    logic                    CLK;
    logic                    RST;
    instrWord                instr;
    logic                    regWriteEn;
    logic [regAddrWidth-1:0] writeAddr;
    logic [xlen-1:0]         writeData;
    logic                    regWrite;
    logic                    memWrite;
    logic                    jump;
    logic                    branch;
    logic [2:0]              memCtl;
    logic [3:0]              aluCtl;
    logic                    branchSrc;
    logic                    srcASel;
    logic                    srcBSel;
    logic [1:0]              resultSel;
    logic [regAddrWidth-1:0] rd;
    logic [regAddrWidth-1:0] rs1;
    logic [regAddrWidth-1:0] rs2;
    logic [xlen-1:0]         readData1;
    logic [xlen-1:0]         readData2;
    logic [xlen-1:0]         immExt;

    string       caseNames [maxCases];
    logic [31:0] caseData  [maxCases][numFields];
    int          caseCount = 0;
    logic        loaded    = 1'b0;              // Starts the watchdog

    tbClock #(
        .periodNs    (periodNs),
        .resetCycles (resetCycles)
    ) clkGen (
        .CLK (CLK),
        .RST (RST)
    );

    decodeStage #(
        .numRegs (32)
    ) UUT (
        .CLK        (CLK),
        .RST        (RST),
        .instr      (instr),
        .regWriteEn (regWriteEn),
        .writeAddr  (writeAddr),
        .writeData  (writeData),
        .regWrite   (regWrite),
        .memWrite   (memWrite),
        .jump       (jump),
        .branch     (branch),
        .memCtl     (memCtl),
        .aluCtl     (aluCtl),
        .branchSrc  (branchSrc),
        .srcASel    (srcASel),
        .srcBSel    (srcBSel),
        .resultSel  (resultSel),
        .rd         (rd),
        .rs1        (rs1),
        .rs2        (rs2),
        .readData1  (readData1),
        .readData2  (readData2),
        .immExt     (immExt)
    );

    //////////////////////////////////////////////////
    // Error handling and compare
    //////////////////////////////////////////////////
    task automatic abortRun();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic checkValue(input string caseName, input string signal,
                              input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s %s: expected %h, actual %h", caseName, signal,
                     expected, actual);
            abortRun();
        end
    endtask

    // Reads every case line and skips comments and blank lines
    task automatic loadCases();
        int          fd;
        int          n;
        string       line;
        string       name;
        logic [31:0] vals [numFields];
        fd = $fopen("tests/decodeCases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the case file tests/decodeCases.txt");
            abortRun();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                name, vals[0], vals[1], vals[2], vals[3], vals[4], vals[5],
                                vals[6], vals[7], vals[8], vals[9], vals[10], vals[11],
                                vals[12], vals[13], vals[14], vals[15], vals[16]);
                    if (n != numFields + 1) begin
                        $display("Malformed line in the case file: %s", line);
                        abortRun();
                    end else if (caseCount == maxCases) begin
                        $display("Case file holds more than %0d cases", maxCases);
                        abortRun();
                    end else begin
                        caseNames[caseCount] = name;
                        caseData[caseCount]  = vals;
                        caseCount++;
                    end
                end
            end
            $fclose(fd);
        end
        if (caseCount == 0) begin
            $display("Case file holds no cases");
            abortRun();
        end
    endtask

    //////////////////////////////////////////////////
    // One case per clock cycle
    //////////////////////////////////////////////////
    task automatic runCase(input int idx);
        logic [31:0] word;
        string       name;
        word = caseData[idx][0];
        name = caseNames[idx];
        @(posedge CLK);
        #1;                                             // Drive just after the edge
        instr      = word;
        regWriteEn = caseData[idx][1][0];
        writeAddr  = caseData[idx][2][regAddrWidth-1:0];
        writeData  = caseData[idx][3];
        #(periodNs - 2);                                // Sample just before the next edge
        checkValue(name, "regWrite",  caseData[idx][4],  32'(regWrite));
        checkValue(name, "memWrite",  caseData[idx][5],  32'(memWrite));
        checkValue(name, "jump",      caseData[idx][6],  32'(jump));
        checkValue(name, "branch",    caseData[idx][7],  32'(branch));
        checkValue(name, "memCtl",    caseData[idx][8],  32'(memCtl));
        checkValue(name, "aluCtl",    caseData[idx][9],  32'(aluCtl));
        checkValue(name, "branchSrc", caseData[idx][10], 32'(branchSrc));
        checkValue(name, "srcASel",   caseData[idx][11], 32'(srcASel));
        checkValue(name, "srcBSel",   caseData[idx][12], 32'(srcBSel));
        checkValue(name, "resultSel", caseData[idx][13], 32'(resultSel));
        checkValue(name, "readData1", caseData[idx][14], readData1);
        checkValue(name, "readData2", caseData[idx][15], readData2);
        checkValue(name, "immExt",    caseData[idx][16], immExt);
        // Register fields sit at fixed RV32I bit positions
        checkValue(name, "rd",  32'(word[11:7]),  32'(rd));
        checkValue(name, "rs1", 32'(word[19:15]), 32'(rs1));
        checkValue(name, "rs2", 32'(word[24:20]), 32'(rs2));
    endtask

    initial begin
        instr      = '0;                                // Illegal opcode while in reset
        regWriteEn = 1'b0;
        writeAddr  = '0;
        writeData  = '0;
        loadCases();
        loaded = 1'b1;
        wait (RST === 1'b1);                            // Whole reset pulse first
        wait (RST === 1'b0);
        for (int i = 0; i < caseCount; i++) begin
            runCase(i);
        end
        $display("** PASS **");
        $finish;
    end

    // Watchdog sized from reset length and case count
    initial begin
        wait (loaded === 1'b1);
        #((resetCycles + caseCount + 20) * periodNs);
        $display("Timeout: the cases did not complete in the expected time");
        abortRun();
    end

endmodule

// File: decodeStage.f
rtl/decodePkg.sv
rtl/controlUnit.sv
rtl/registerFile.sv
rtl/immediateExtender.sv
rtl/decodeStage.sv
tests/tbClock.sv
tests/decodeStageTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it.
# The run counts as passed only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1
logFile=sim.log

verilator --binary -j 0 --top-module decodeStageTb -Mdir obj_dir -f decodeStage.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VdecodeStageTb > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qxF '** PASS **' "$logFile"; then
    echo "Simulation passed"
    exit 0
else
    echo "Pass line not found in $logFile"
    exit 1
fi

// File: tests/decodeCases.txt
# name instr wrEn wrAddr wrData regWrite memWrite jump branch memCtl aluCtl
#   branchSrc srcASel srcBSel resultSel readData1 readData2 immExt, all hex
add       002081B3 0 00 00000000 1 0 0 0 0 0 0 0 0 0 00000000 00000000 00000002
sub       40418233 0 00 00000000 1 0 0 0 0 1 0 0 0 0 00000000 00000000 00000404
sll       006292B3 0 00 00000000 1 0 0 0 0 2 0 0 0 0 00000000 00000000 00000006
slt       0083A3B3 0 00 00000000 1 0 0 0 0 3 0 0 0 0 00000000 00000000 00000008
sltu      00A4B4B3 0 00 00000000 1 0 0 0 0 4 0 0 0 0 00000000 00000000 0000000A
xor       00C5C5B3 0 00 00000000 1 0 0 0 0 5 0 0 0 0 00000000 00000000 0000000C
srl       00E6D6B3 0 00 00000000 1 0 0 0 0 6 0 0 0 0 00000000 00000000 0000000E
sra       4107D7B3 0 00 00000000 1 0 0 0 0 7 0 0 0 0 00000000 00000000 00000410
or        0128E8B3 0 00 00000000 1 0 0 0 0 8 0 0 0 0 00000000 00000000 00000012
and       0149F9B3 0 00 00000000 1 0 0 0 0 9 0 0 0 0 00000000 00000000 00000014
mulNop    036A8AB3 0 00 00000000 0 0 0 0 0 0 0 0 0 0 00000000 00000000 00000036
addi      FFFB8B93 0 00 00000000 1 0 0 0 0 0 0 0 1 0 00000000 00000000 FFFFFFFF
slti      005C2C13 0 00 00000000 1 0 0 0 0 3 0 0 1 0 00000000 00000000 00000005
sltiu     7FFCBC93 0 00 00000000 1 0 0 0 0 4 0 0 1 0 00000000 00000000 000007FF
xori      800D4D13 0 00 00000000 1 0 0 0 0 5 0 0 1 0 00000000 00000000 FFFFF800
srli      003DDD93 0 00 00000000 1 0 0 0 0 6 0 0 1 0 00000000 00000000 00000003
srai      404E5E13 0 00 00000000 1 0 0 0 0 7 0 0 1 0 00000000 00000000 00000404
ori       0F0EEE93 0 00 00000000 1 0 0 0 0 8 0 0 1 0 00000000 00000000 000000F0
andi      0FFF7F13 0 00 00000000 1 0 0 0 0 9 0 0 1 0 00000000 00000000 000000FF
lb        00808283 0 00 00000000 1 0 0 0 0 0 0 0 1 1 00000000 00000000 00000008
lh        FFC09283 0 00 00000000 1 0 0 0 2 0 0 0 1 1 00000000 00000000 FFFFFFFC
lw        0100A283 0 00 00000000 1 0 0 0 4 0 0 0 1 1 00000000 00000000 00000010
lbu       0010C283 0 00 00000000 1 0 0 0 1 0 0 0 1 1 00000000 00000000 00000001
lhu       0020D283 0 00 00000000 1 0 0 0 3 0 0 0 1 1 00000000 00000000 00000002
lwuNop    0000E283 0 00 00000000 0 0 0 0 0 0 0 0 1 1 00000000 00000000 00000000
sb        002082A3 0 00 00000000 0 1 0 0 0 0 0 0 1 0 00000000 00000000 00000005
sh        FE209D23 0 00 00000000 0 1 0 0 2 0 0 0 1 0 00000000 00000000 FFFFFFFA
sw        7E20AE23 0 00 00000000 0 1 0 0 4 0 0 0 1 0 00000000 00000000 000007FC
sdNop     0020B023 0 00 00000000 0 0 0 0 0 0 0 0 1 0 00000000 00000000 00000000
beq       00208863 0 00 00000000 0 0 0 1 0 B 0 0 0 0 00000000 00000000 00000010
bne       FE209CE3 0 00 00000000 0 0 0 1 0 C 0 0 0 0 00000000 00000000 FFFFFFF8
blt       0020C263 0 00 00000000 0 0 0 1 0 3 0 0 0 0 00000000 00000000 00000004
bge       0020D0E3 0 00 00000000 0 0 0 1 0 D 0 0 0 0 00000000 00000000 00000800
bltu      8020E063 0 00 00000000 0 0 0 1 0 4 0 0 0 0 00000000 00000000 FFFFF000
bgeu      0220F063 0 00 00000000 0 0 0 1 0 E 0 0 0 0 00000000 00000000 00000020
jal       001000EF 0 00 00000000 1 0 1 0 0 0 0 0 0 2 00000000 00000000 00000800
jalBack   FFFFF06F 0 00 00000000 1 0 1 0 0 0 0 0 0 2 00000000 00000000 FFFFFFFE
jalr      00C280E7 0 00 00000000 1 0 1 0 0 0 1 0 1 2 00000000 00000000 0000000C
lui       123452B7 0 00 00000000 1 0 0 0 0 A 0 0 1 0 00000000 00000000 12345000
auipc     FFFFF317 0 00 00000000 1 0 0 0 0 0 0 1 1 0 00000000 00000000 FFFFF000
fence     0FF0000F 0 00 00000000 0 0 0 0 0 0 0 0 0 0 00000000 00000000 000000FF
ecall     00000073 0 00 00000000 0 0 0 0 0 0 0 0 0 0 00000000 00000000 00000000
ebreak    00100073 0 00 00000000 0 0 0 0 0 0 0 0 0 0 00000000 00000000 00000001
illegal   FFFFFFFF 0 00 00000000 0 0 0 0 0 0 0 0 0 0 00000000 00000000 FFFFFFFF
writeFwd  00628033 1 05 DEADBEEF 1 0 0 0 0 0 0 0 0 0 DEADBEEF 00000000 00000006
writeFwd2 00628033 1 06 12345678 1 0 0 0 0 0 0 0 0 0 DEADBEEF 12345678 00000006
writeX0   00500033 1 00 FFFFFFFF 1 0 0 0 0 0 0 0 0 0 00000000 DEADBEEF 00000005
readX0    00600033 0 00 00000000 1 0 0 0 0 0 0 0 0 0 00000000 12345678 00000006
writeX31  00628033 1 1F A5A5A5A5 1 0 0 0 0 0 0 0 0 0 DEADBEEF 12345678 00000006
readX31   005F8033 0 00 00000000 1 0 0 0 0 0 0 0 0 0 A5A5A5A5 DEADBEEF 00000005
